// File: hdl/user_io_config.svh
// build-time constants of the host-link block
// configuration string length and core type byte
`ifndef USER_IO_CONFIG_SVH
`define USER_IO_CONFIG_SVH

// number of bytes in conf_str
// the top level and core_io_regs size the string port from this
`define UIO_STRLEN 8

// first MISO byte of every transaction
// a4 marks an 8 bit core to the I/O controller
`define UIO_CORE_TYPE 8'ha4

`endif

// File: hdl/user_io_pkg.sv
// shared types of the host-link block
// command opcodes, decoder states and the internal bus address
package user_io_pkg;

	// command byte sent first by the I/O controller
	typedef enum logic [7:0] {
		CMD_BUT_SW      = 8'h01,
		CMD_JOY0        = 8'h02,
		CMD_JOY1        = 8'h03,
		CMD_CONF_STR    = 8'h14,
		CMD_STATUS      = 8'h15,
		// sd commands occupy 16 to 1c
		CMD_SD_STATUS   = 8'h16,
		CMD_SD_WRITE    = 8'h17,
		CMD_SD_READ     = 8'h18,
		CMD_SD_CONF     = 8'h19,
		CMD_JOY_ANALOG  = 8'h1a,
		CMD_IMG_MOUNTED = 8'h1c
	} cmd_e;

	// idle until a byte arrives, then one bus cycle
	typedef enum logic {
		DEC_IDLE,
		DEC_BUS
	} dec_state_e;

	// bus address is the command plus the byte index in the transaction
	typedef struct packed {
		cmd_e       cmd;
		logic [7:0] idx;
	} wb_addr_t;

endpackage

// File: hdl/user_io_if.sv
// spi_byte_if between byte framing and the command decoder
// wb_if for the Wishbone classic bus from the decoder to the slaves
interface spi_byte_if;
	// one-cycle pulse per completed byte
	logic       rx_valid;
	logic [7:0] rx_byte;
	// byte position, 0 is the command
	logic [7:0] rx_idx;
	// response byte, loaded into the shifter at each byte boundary
	logic [7:0] tx_byte;

	modport frame (output rx_valid, rx_byte, rx_idx, input tx_byte);
	modport decoder (input rx_valid, rx_byte, rx_idx, output tx_byte);
endinterface

interface wb_if;
	logic                   cyc;
	logic                   stb;
	logic                   we;
	user_io_pkg::wb_addr_t  adr;
	logic [7:0]             dat_w;
	logic [7:0]             dat_r;
	// single-cycle acknowledge
	logic                   ack;

	modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);
	modport slave (input cyc, stb, we, adr, dat_w, output dat_r, ack);
endinterface

// File: hdl/spi_frame.sv
// SPI framing: bit and byte counters, MOSI byte assembly
// and the MISO transmit shifter
`include "user_io_config.svh"

module spi_frame (
	input  logic        spi_sck,
	input  logic        SPI_SS_IO,
	input  logic        spi_mosi,
	output logic        spi_miso,
	spi_byte_if.frame   byte_port
);

	logic [2:0] bit_cnt;
	logic [7:0] byte_cnt;
	// first seven bits of the byte in flight
	logic [6:0] sbuf;
	logic [7:0] tx_shift;
	logic       miso_bit;
	logic       miso_oe;

	// counters, shifter load and byte strobe
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt <= 3'd0;
			byte_cnt <= 8'd0;
			byte_port.rx_valid <= 1'b0;
			// core type goes out as the first byte
			tx_shift <= `UIO_CORE_TYPE;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			byte_port.rx_valid <= 1'b0;
			if (bit_cnt == 3'd7) begin
				// response from the decoder for the next byte
				tx_shift <= byte_port.tx_byte;
				byte_port.rx_valid <= 1'b1;
				// byte index sticks at 255
				if (byte_cnt != 8'd255)
					byte_cnt <= byte_cnt + 8'd1;
			end
		end
	end

	// byte assembly, MSB first
	always_ff @(posedge spi_sck) begin
		if (bit_cnt == 3'd7) begin
			byte_port.rx_byte <= {sbuf, spi_mosi};
			// index of the byte just completed
			byte_port.rx_idx <= byte_cnt;
		end else begin
			sbuf <= {sbuf[5:0], spi_mosi};
		end
	end

	// MISO output enable, off while deselected
	always_ff @(negedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			miso_oe <= 1'b0;
		else
			miso_oe <= 1'b1;
	end

	// bit 7 at bit_cnt 0, bit 0 at bit_cnt 7
	always_ff @(negedge spi_sck)
		miso_bit <= tx_shift[~bit_cnt];

	assign spi_miso = miso_oe ? miso_bit : 1'bz;

endmodule

// File: hdl/cmd_decoder.sv
// command decoder that latches the command byte and runs one
// Wishbone cycle per received byte on the io or sd bus
module cmd_decoder (
	input  logic         spi_sck,
	input  logic         SPI_SS_IO,
	spi_byte_if.decoder  byte_port,
	wb_if.master         io_bus,
	wb_if.master         sd_bus
);

	user_io_pkg::dec_state_e state;
	user_io_pkg::cmd_e       cmd_r;
	user_io_pkg::cmd_e       cur_cmd;
	user_io_pkg::wb_addr_t   adr_r;
	logic       we_r;
	logic       rd_r;
	logic       sel_sd_r;
	logic [7:0] dat_w_r;
	logic       cur_rd;
	logic       cur_sd;
	logic       bus_ack;
	logic [7:0] bus_dat_r;

	// byte 0 carries the command itself
	assign cur_cmd = (byte_port.rx_idx == 8'd0) ?
		user_io_pkg::cmd_e'(byte_port.rx_byte) : cmd_r;

	// commands that answer on MISO
	always_comb begin
		case (cur_cmd)
			user_io_pkg::CMD_CONF_STR,
			user_io_pkg::CMD_SD_STATUS,
			user_io_pkg::CMD_SD_READ: cur_rd = 1'b1;
			default:                  cur_rd = 1'b0;
		endcase
	end

	// 16 to 1c belong to the sd port apart from the analog stick
	assign cur_sd = (cur_cmd >= user_io_pkg::CMD_SD_STATUS) &&
		(cur_cmd <= user_io_pkg::CMD_IMG_MOUNTED) &&
		(cur_cmd != user_io_pkg::CMD_JOY_ANALOG);

	// FSM and the response byte
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			state <= user_io_pkg::DEC_IDLE;
			byte_port.tx_byte <= 8'h00;
		end else begin
			case (state)
				user_io_pkg::DEC_IDLE: begin
					if (byte_port.rx_valid)
						state <= user_io_pkg::DEC_BUS;
				end
				user_io_pkg::DEC_BUS: begin
					if (bus_ack) begin
						state <= user_io_pkg::DEC_IDLE;
						// zero unless this byte was a read
						byte_port.tx_byte <= rd_r ? bus_dat_r : 8'h00;
					end
				end
				default: state <= user_io_pkg::DEC_IDLE;
			endcase
		end
	end

	// bus request fields captured with each byte
	always_ff @(posedge spi_sck) begin
		if (byte_port.rx_valid && state == user_io_pkg::DEC_IDLE) begin
			if (byte_port.rx_idx == 8'd0)
				cmd_r <= cur_cmd;
			adr_r.cmd <= cur_cmd;
			adr_r.idx <= byte_port.rx_idx;
			// the command byte of a write command is only a read probe
			we_r <= ~cur_rd && (byte_port.rx_idx != 8'd0);
			rd_r <= cur_rd;
			sel_sd_r <= cur_sd;
			dat_w_r <= byte_port.rx_byte;
		end
	end

	// strobe only the selected slave
	assign io_bus.cyc = (state == user_io_pkg::DEC_BUS) && !sel_sd_r;
	assign io_bus.stb = (state == user_io_pkg::DEC_BUS) && !sel_sd_r;
	assign sd_bus.cyc = (state == user_io_pkg::DEC_BUS) && sel_sd_r;
	assign sd_bus.stb = (state == user_io_pkg::DEC_BUS) && sel_sd_r;
	assign io_bus.we = we_r;
	assign sd_bus.we = we_r;
	assign io_bus.adr = adr_r;
	assign sd_bus.adr = adr_r;
	assign io_bus.dat_w = dat_w_r;
	assign sd_bus.dat_w = dat_w_r;

	assign bus_ack = sel_sd_r ? sd_bus.ack : io_bus.ack;
	assign bus_dat_r = sel_sd_r ? sd_bus.dat_r : io_bus.dat_r;

endmodule

// File: hdl/core_io_regs.sv
// core I/O register slave: joysticks, buttons and switches,
// status, analog sticks and configuration string reads
`include "user_io_config.svh"

module core_io_regs (
	input  logic                      spi_sck,
	input  logic                      SPI_SS_IO,
	wb_if.slave                       bus,
	input  logic [8*`UIO_STRLEN-1:0]  conf_str,
	output logic [7:0]                joystick_0,
	output logic [7:0]                joystick_1,
	output logic [15:0]               joystick_analog_0,
	output logic [15:0]               joystick_analog_1,
	output logic [1:0]                buttons,
	output logic [1:0]                switches,
	output logic                      scandoubler_disable,
	output logic [7:0]                status
);

	logic [4:0] but_sw;
	logic [2:0] stick_idx;
	logic       access;

	// first cycle of a bus request
	assign access = bus.cyc && bus.stb && !bus.ack;

	// ack one cycle after stb, for one cycle
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			bus.ack <= 1'b0;
		else
			bus.ack <= access;
	end

	// registers hold their values across transactions
	always_ff @(posedge spi_sck) begin
		if (access) begin
			bus.dat_r <= 8'h00;
			if (bus.we) begin
				case (bus.adr.cmd)
					user_io_pkg::CMD_BUT_SW: if (bus.adr.idx == 8'd1) but_sw <= bus.dat_w[4:0];
					user_io_pkg::CMD_JOY0:   if (bus.adr.idx == 8'd1) joystick_0 <= bus.dat_w;
					user_io_pkg::CMD_JOY1:   if (bus.adr.idx == 8'd1) joystick_1 <= bus.dat_w;
					user_io_pkg::CMD_STATUS: if (bus.adr.idx == 8'd1) status <= bus.dat_w;
					user_io_pkg::CMD_JOY_ANALOG: begin
						// stick index, then high byte, then low byte
						if (bus.adr.idx == 8'd1)
							stick_idx <= bus.dat_w[2:0];
						else if (bus.adr.idx == 8'd2 && stick_idx == 3'd0)
							joystick_analog_0[15:8] <= bus.dat_w;
						else if (bus.adr.idx == 8'd2 && stick_idx == 3'd1)
							joystick_analog_1[15:8] <= bus.dat_w;
						else if (bus.adr.idx == 8'd3 && stick_idx == 3'd0)
							joystick_analog_0[7:0] <= bus.dat_w;
						else if (bus.adr.idx == 8'd3 && stick_idx == 3'd1)
							joystick_analog_1[7:0] <= bus.dat_w;
					end
					default: ;
				endcase
			end else if (bus.adr.cmd == user_io_pkg::CMD_CONF_STR &&
				bus.adr.idx < `UIO_STRLEN) begin
				// most significant byte of the string comes first
				bus.dat_r <= conf_str[8*(`UIO_STRLEN - 1 - int'(bus.adr.idx)) +: 8];
			end
		end
	end

	assign buttons = but_sw[1:0];
	assign switches = but_sw[3:2];
	assign scandoubler_disable = but_sw[4];

endmodule

// File: hdl/sd_port.sv
// sd card slave: request status and LBA reads, sector data strobes,
// buffer address counter and image mount pulse
module sd_port (
	input  logic        spi_sck,
	input  logic        SPI_SS_IO,
	wb_if.slave         bus,
	input  logic [31:0] sd_lba,
	input  logic        sd_rd,
	input  logic        sd_wr,
	input  logic        sd_conf,
	input  logic        sd_sdhc,
	output logic        sd_ack,
	output logic        sd_ack_conf,
	output logic [7:0]  sd_dout,
	output logic        sd_dout_strobe,
	input  logic [7:0]  sd_din,
	output logic        sd_din_strobe,
	output logic [8:0]  sd_buff_addr,
	output logic        img_mounted
);

	logic [31:0] lba_r;
	logic        access;
	logic        acc_wr;
	logic        acc_rd;

	assign access = bus.cyc && bus.stb && !bus.ack;
	assign acc_wr = access && bus.we;
	assign acc_rd = access && !bus.we;

	// handshake, cleared at the end of every transaction
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bus.ack <= 1'b0;
			sd_ack <= 1'b0;
			sd_ack_conf <= 1'b0;
			sd_dout_strobe <= 1'b0;
			sd_din_strobe <= 1'b0;
			img_mounted <= 1'b0;
			sd_buff_addr <= 9'd0;
		end else begin
			bus.ack <= access;
			sd_dout_strobe <= 1'b0;
			sd_din_strobe <= 1'b0;
			img_mounted <= 1'b0;
			// step the buffer address after each strobe, stop at 511
			if ((sd_dout_strobe || sd_din_strobe) && sd_buff_addr != 9'd511)
				sd_buff_addr <= sd_buff_addr + 9'd1;
			if (acc_wr && (bus.adr.cmd == user_io_pkg::CMD_SD_WRITE ||
				bus.adr.cmd == user_io_pkg::CMD_SD_CONF)) begin
				sd_dout_strobe <= 1'b1;
				sd_ack <= 1'b1;
				if (bus.adr.cmd == user_io_pkg::CMD_SD_CONF)
					sd_ack_conf <= 1'b1;
			end
			// sector byte fetched by the controller
			if (acc_rd && bus.adr.cmd == user_io_pkg::CMD_SD_READ) begin
				sd_din_strobe <= 1'b1;
				sd_ack <= 1'b1;
			end
			if (acc_wr && bus.adr.cmd == user_io_pkg::CMD_IMG_MOUNTED)
				img_mounted <= 1'b1;
		end
	end

	// read data, sector output byte and LBA snapshot
	always_ff @(posedge spi_sck) begin
		if (access) begin
			bus.dat_r <= 8'h00;
			if (bus.we) begin
				sd_dout <= bus.dat_w;
			end else if (bus.adr.cmd == user_io_pkg::CMD_SD_READ) begin
				bus.dat_r <= sd_din;
			end else if (bus.adr.cmd == user_io_pkg::CMD_SD_STATUS) begin
				if (bus.adr.idx == 8'd0) begin
					// request byte, LBA frozen for the following bytes
					bus.dat_r <= {4'h5, sd_conf, sd_sdhc, sd_wr, sd_rd};
					lba_r <= sd_lba;
				end else if (bus.adr.idx <= 8'd4) begin
					bus.dat_r <= lba_r[8*(4 - int'(bus.adr.idx)) +: 8];
				end
			end
		end
	end

endmodule

// File: hdl/user_io_top.sv
// top level of the host-link block
// SPI framing, command decoder and the two register slaves
`include "user_io_config.svh"

module user_io_top (
	input  logic                      spi_sck,
	input  logic                      SPI_SS_IO,
	input  logic                      spi_mosi,
	output logic                      spi_miso,
	input  logic [8*`UIO_STRLEN-1:0]  conf_str,
	output logic [7:0]                joystick_0,
	output logic [7:0]                joystick_1,
	output logic [15:0]               joystick_analog_0,
	output logic [15:0]               joystick_analog_1,
	output logic [1:0]                buttons,
	output logic [1:0]                switches,
	output logic                      scandoubler_disable,
	output logic [7:0]                status,
	input  logic [31:0]               sd_lba,
	input  logic                      sd_rd,
	input  logic                      sd_wr,
	input  logic                      sd_conf,
	input  logic                      sd_sdhc,
	output logic                      sd_ack,
	output logic                      sd_ack_conf,
	output logic [7:0]                sd_dout,
	output logic                      sd_dout_strobe,
	input  logic [7:0]                sd_din,
	output logic                      sd_din_strobe,
	output logic [8:0]                sd_buff_addr,
	output logic                      img_mounted
);

	spi_byte_if byte_if ();
	// one bus per slave
	wb_if io_bus ();
	wb_if sd_bus ();

	spi_frame u_frame (
		.spi_sck   (spi_sck),
		.SPI_SS_IO (SPI_SS_IO),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.byte_port (byte_if.frame)
	);

	cmd_decoder u_decoder (
		.spi_sck   (spi_sck),
		.SPI_SS_IO (SPI_SS_IO),
		.byte_port (byte_if.decoder),
		.io_bus    (io_bus.master),
		.sd_bus    (sd_bus.master)
	);

	core_io_regs u_io_regs (
		.spi_sck             (spi_sck),
		.SPI_SS_IO           (SPI_SS_IO),
		.bus                 (io_bus.slave),
		.conf_str            (conf_str),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.joystick_analog_0   (joystick_analog_0),
		.joystick_analog_1   (joystick_analog_1),
		.buttons             (buttons),
		.switches            (switches),
		.scandoubler_disable (scandoubler_disable),
		.status              (status)
	);

	sd_port u_sd_port (
		.spi_sck        (spi_sck),
		.SPI_SS_IO      (SPI_SS_IO),
		.bus            (sd_bus.slave),
		.sd_lba         (sd_lba),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.sd_conf        (sd_conf),
		.sd_sdhc        (sd_sdhc),
		.sd_ack         (sd_ack),
		.sd_ack_conf    (sd_ack_conf),
		.sd_dout        (sd_dout),
		.sd_dout_strobe (sd_dout_strobe),
		.sd_din         (sd_din),
		.sd_din_strobe  (sd_din_strobe),
		.sd_buff_addr   (sd_buff_addr),
		.img_mounted    (img_mounted)
	);

endmodule

// File: bench/tb_user_io.sv
// testbench for the host-link block
// table of SPI transactions with expected MISO bytes, core outputs and sd strobes
`include "user_io_config.svh"

module tb_user_io;

	localparam int NROWS = 14;
	localparam int MAXP = 10;
	// 40 cycles per row plus margin for reset and gaps
	localparam int TIMEOUT = 40 * NROWS + 200;

	logic                     spi_sck;
	logic                     SPI_SS_IO;
	logic                     spi_mosi;
	wire                      spi_miso;
	logic [8*`UIO_STRLEN-1:0] conf_str;
	logic [7:0]               joystick_0;
	logic [7:0]               joystick_1;
	logic [15:0]              joystick_analog_0;
	logic [15:0]              joystick_analog_1;
	logic [1:0]               buttons;
	logic [1:0]               switches;
	logic                     scandoubler_disable;
	logic [7:0]               status;
	logic [31:0]              sd_lba;
	logic                     sd_rd;
	logic                     sd_wr;
	logic                     sd_conf;
	logic                     sd_sdhc;
	logic                     sd_ack;
	logic                     sd_ack_conf;
	logic [7:0]               sd_dout;
	logic                     sd_dout_strobe;
	logic [7:0]               sd_din;
	logic                     sd_din_strobe;
	logic [8:0]               sd_buff_addr;
	logic                     img_mounted;

	// stimulus table of command, payload, payload length and expected MISO bytes
	logic [7:0] tab_cmd [NROWS];
	logic [7:0] tab_pay [NROWS][MAXP];
	int         tab_len [NROWS];
	logic [7:0] tab_miso [NROWS][MAXP+1];
	int         nrows = 0;

	integer     seed;
	logic [31:0] rnd;
	string      conf_text = "MISTCORE";
	int         errors = 0;
	int         npass = 0;
	int         cycles = 0;
	int         cur_row = 0;
	int         dout_cnt = 0;
	int         din_cnt = 0;
	int         img_cnt = 0;

	// expected core registers and whether they were written yet
	logic [4:0]  m_but;
	logic [7:0]  m_joy0;
	logic [7:0]  m_joy1;
	logic [7:0]  m_status;
	logic [15:0] m_ana0;
	logic [15:0] m_ana1;
	bit         k_but = 0;
	bit         k_joy0 = 0;
	bit         k_joy1 = 0;
	bit         k_status = 0;
	bit         k_ana0 = 0;
	bit         k_ana1 = 0;

	user_io_top UUT (.*);

	initial begin
		spi_sck = 1'b0;
		forever #4 spi_sck = ~spi_sck;
	end

	always @(posedge spi_sck) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("timeout: the run did not end within %0d clock cycles", TIMEOUT);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	// strobe counters and the sd_dout byte at each pulse
	always @(posedge spi_sck) begin
		if (sd_dout_strobe === 1'b1) begin
			if (dout_cnt < MAXP)
				check_value($sformatf("row %0d sd_dout pulse %0d", cur_row, dout_cnt),
					sd_dout, tab_pay[cur_row][dout_cnt]);
			dout_cnt++;
		end
		if (sd_din_strobe === 1'b1)
			din_cnt++;
		if (img_mounted === 1'b1)
			img_cnt++;
	end

	// response of a read command at one byte index
	function automatic logic [7:0] read_value(input logic [7:0] cmd, input int idx);
		case (cmd)
			user_io_pkg::CMD_CONF_STR:
				return (idx < `UIO_STRLEN) ? conf_text[idx] : 8'h00;
			user_io_pkg::CMD_SD_STATUS: begin
				case (idx)
					0: return {4'h5, sd_conf, sd_sdhc, sd_wr, sd_rd};
					1: return sd_lba[31:24];
					2: return sd_lba[23:16];
					3: return sd_lba[15:8];
					4: return sd_lba[7:0];
					default: return 8'h00;
				endcase
			end
			user_io_pkg::CMD_SD_READ: return sd_din;
			default: return 8'h00;
		endcase
	endfunction

	task automatic add_row(input logic [7:0] cmd, input int len,
		input logic [8*MAXP-1:0] pay);
		int  i;
		bit  rd;
		rd = (cmd == user_io_pkg::CMD_CONF_STR) || (cmd == user_io_pkg::CMD_SD_STATUS) ||
			(cmd == user_io_pkg::CMD_SD_READ);
		tab_cmd[nrows] = cmd;
		tab_len[nrows] = len;
		for (i = 0; i < MAXP; i++)
			tab_pay[nrows][i] = pay[8*(MAXP-1-i) +: 8];
		tab_miso[nrows][0] = `UIO_CORE_TYPE;
		// a read answer goes out two bytes after the byte that asked for it
		for (i = 1; i <= MAXP; i++)
			tab_miso[nrows][i] = (rd && i >= 2) ? read_value(cmd, i - 2) : 8'h00;
		nrows++;
	endtask

	task automatic build_table;
		add_row(user_io_pkg::CMD_BUT_SW, 1, {8'h1b, 72'h0});
		add_row(user_io_pkg::CMD_JOY0, 1, {8'h5a, 72'h0});
		add_row(user_io_pkg::CMD_JOY1, 1, {8'hc3, 72'h0});
		add_row(user_io_pkg::CMD_STATUS, 1, {8'h81, 72'h0});
		add_row(user_io_pkg::CMD_JOY_ANALOG, 3, {24'h00_12_34, 56'h0});
		add_row(user_io_pkg::CMD_JOY_ANALOG, 3, {24'h01_56_78, 56'h0});
		add_row(user_io_pkg::CMD_JOY_ANALOG, 3, {24'h05_ee_ff, 56'h0});
		// runs past the end of the string
		add_row(user_io_pkg::CMD_CONF_STR, 10, 80'h0);
		add_row(user_io_pkg::CMD_SD_STATUS, 6, 80'h0);
		add_row(user_io_pkg::CMD_SD_READ, 4, 80'h0);
		add_row(user_io_pkg::CMD_SD_WRITE, 3, {24'h11_22_33, 56'h0});
		add_row(user_io_pkg::CMD_SD_CONF, 2, {16'h44_55, 64'h0});
		add_row(user_io_pkg::CMD_IMG_MOUNTED, 2, {16'h01_01, 64'h0});
		add_row(user_io_pkg::CMD_BUT_SW, 1, {8'h06, 72'h0});
	endtask

	task automatic update_model(input int r);
		if (tab_len[r] >= 1) begin
			case (tab_cmd[r])
				user_io_pkg::CMD_BUT_SW: begin
					m_but = tab_pay[r][0][4:0];
					k_but = 1;
				end
				user_io_pkg::CMD_JOY0: begin
					m_joy0 = tab_pay[r][0];
					k_joy0 = 1;
				end
				user_io_pkg::CMD_JOY1: begin
					m_joy1 = tab_pay[r][0];
					k_joy1 = 1;
				end
				user_io_pkg::CMD_STATUS: begin
					m_status = tab_pay[r][0];
					k_status = 1;
				end
				// stick index first, then high and low byte
				// sticks other than 0 and 1 are ignored
				user_io_pkg::CMD_JOY_ANALOG: begin
					if (tab_len[r] >= 3 && tab_pay[r][0] == 8'd0) begin
						m_ana0 = {tab_pay[r][1], tab_pay[r][2]};
						k_ana0 = 1;
					end else if (tab_len[r] >= 3 && tab_pay[r][0] == 8'd1) begin
						m_ana1 = {tab_pay[r][1], tab_pay[r][2]};
						k_ana1 = 1;
					end
				end
				default: ;
			endcase
		end
	endtask

	task automatic check_regs;
		if (k_but) begin
			check_value("buttons", buttons, m_but[1:0]);
			check_value("switches", switches, m_but[3:2]);
			check_value("scandoubler_disable", scandoubler_disable, m_but[4]);
		end
		if (k_joy0)
			check_value("joystick_0", joystick_0, m_joy0);
		if (k_joy1)
			check_value("joystick_1", joystick_1, m_joy1);
		if (k_status)
			check_value("status", status, m_status);
		if (k_ana0)
			check_value("joystick_analog_0", joystick_analog_0, m_ana0);
		if (k_ana1)
			check_value("joystick_analog_1", joystick_analog_1, m_ana1);
	endtask

	// sd handshake while the transaction is still selected
	task automatic check_sd(input int r);
		int exp_dout;
		int exp_din;
		int exp_img;
		exp_dout = 0;
		exp_din = 0;
		exp_img = 0;
		case (tab_cmd[r])
			user_io_pkg::CMD_SD_WRITE, user_io_pkg::CMD_SD_CONF: exp_dout = tab_len[r];
			// the command byte reads a sector byte too
			user_io_pkg::CMD_SD_READ: exp_din = tab_len[r] + 1;
			user_io_pkg::CMD_IMG_MOUNTED: exp_img = tab_len[r];
			default: ;
		endcase
		check_value($sformatf("row %0d sd_dout_strobe count", r), dout_cnt, exp_dout);
		check_value($sformatf("row %0d sd_din_strobe count", r), din_cnt, exp_din);
		check_value($sformatf("row %0d img_mounted count", r), img_cnt, exp_img);
		check_value($sformatf("row %0d sd_buff_addr", r), sd_buff_addr, exp_dout + exp_din);
		check_value($sformatf("row %0d sd_ack", r), sd_ack, (exp_dout + exp_din) > 0);
		check_value($sformatf("row %0d sd_ack_conf", r), sd_ack_conf,
			tab_cmd[r] == user_io_pkg::CMD_SD_CONF && exp_dout > 0);
	endtask

	task automatic run_row(input int r);
		logic [7:0] tx [MAXP+1];
		logic [7:0] rx;
		int         nbytes;
		int         errs_before;
		int         i;
		int         b;
		nbytes = tab_len[r] + 1;
		errs_before = errors;
		tx[0] = tab_cmd[r];
		for (i = 0; i < MAXP; i++)
			tx[i+1] = tab_pay[r][i];
		cur_row = r;
		dout_cnt = 0;
		din_cnt = 0;
		img_cnt = 0;
		rx = 8'h00;
		@(posedge spi_sck);
		SPI_SS_IO <= 1'b0;
		spi_mosi <= tx[0][7];
		// MISO sampled and the next MOSI bit driven on each rising edge
		for (b = 0; b < 8*nbytes; b++) begin
			@(posedge spi_sck);
			rx = {rx[6:0], spi_miso};
			if (b % 8 == 7)
				check_value($sformatf("row %0d miso byte %0d", r, b / 8), rx,
					tab_miso[r][b / 8]);
			if (b + 1 < 8*nbytes)
				spi_mosi <= tx[(b + 1) / 8][7 - (b + 1) % 8];
			else
				spi_mosi <= 1'b0;
		end
		// bus cycle of the last byte and its strobes
		repeat (4) @(posedge spi_sck);
		@(negedge spi_sck);
		check_sd(r);
		@(posedge spi_sck);
		SPI_SS_IO <= 1'b1;
		@(posedge spi_sck);
		@(negedge spi_sck);
		// deselect clears the sd handshake
		check_value($sformatf("row %0d sd_ack after SS", r), sd_ack, 1'b0);
		check_value($sformatf("row %0d sd_ack_conf after SS", r), sd_ack_conf, 1'b0);
		check_value($sformatf("row %0d sd_buff_addr after SS", r), sd_buff_addr, 9'd0);
		update_model(r);
		check_regs();
		if (errors == errs_before)
			npass++;
		$display("test %0d cmd %02h len %0d: %s", r, tab_cmd[r], tab_len[r],
			(errors == errs_before) ? "pass" : "fail");
	endtask

	initial begin
		SPI_SS_IO = 1'b1;
		spi_mosi = 1'b0;
		seed = 32'h7698ce94;
		sd_lba = $random(seed);
		rnd = $random(seed);
		sd_din = rnd[7:0];
		rnd = $random(seed);
		{sd_conf, sd_sdhc, sd_wr, sd_rd} = rnd[3:0];
		// first character is the most significant byte
		conf_str = '0;
		for (int i = 0; i < `UIO_STRLEN; i++)
			conf_str = (conf_str << 8) | conf_text[i];
		build_table();
		repeat (10) @(posedge spi_sck);
		for (int r = 0; r < nrows; r++)
			run_row(r);
		$display("%0d of %0d tests passed, %0d errors", npass, nrows, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+hdl
hdl/user_io_pkg.sv
hdl/user_io_if.sv
hdl/spi_frame.sv
hdl/cmd_decoder.sv
hdl/core_io_regs.sv
hdl/sd_port.sv
hdl/user_io_top.sv
bench/tb_user_io.sv

// File: Makefile
# Verilator build and run of the host-link testbench

VERILATOR ?= verilator
TOP       ?= tb_user_io
LOG       ?= sim.log
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

# simulator binary, rebuilt only when a source, header or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $* -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Finished with no errors$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
